// File: rtl/sdram_macros.svh
/* SDRAM controller constants
   Timing in clock cycles, device geometry and the mode register word */
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// Power-up wait before precharge-all, simulation value
`define SDRAM_INIT_WAIT 100

// Cycles between auto-refreshes, simulation value
`define SDRAM_REFRESH_INTERVAL 400

// Precharge to activate
`define SDRAM_T_RP 3
// Refresh to refresh, activate to activate
`define SDRAM_T_RC 10
// Mode register program time
`define SDRAM_T_MRD 3
// Activate to read or write
`define SDRAM_T_RCD 3
// Read command to data on the bus
`define SDRAM_CAS_LATENCY 2
// Write recovery before auto-precharge starts
`define SDRAM_T_WR 2

// Device geometry
`define SDRAM_COL_W 9
`define SDRAM_ROW_W 12
`define SDRAM_BANK_W 2
`define SDRAM_DATA_W 32

// Host address carries {bank, row, column}
`define SDRAM_HOST_ADDR_W (`SDRAM_BANK_W + `SDRAM_ROW_W + `SDRAM_COL_W)

// One mask pin per byte lane
`define SDRAM_DQM_W (`SDRAM_DATA_W / 8)

// Mode word
// M9 single-location write, M6:M4 CAS latency, M3 sequential, M2:M0 burst of one
`define SDRAM_MODE_REG {2'b00, 1'b1, 2'b00, 3'(`SDRAM_CAS_LATENCY), 1'b0, 3'b000}

// Whole power-up sequence runs in one state, so it sets the counter size
`define SDRAM_INIT_SUM (`SDRAM_INIT_WAIT + `SDRAM_T_RP + 2 * `SDRAM_T_RC)
`define SDRAM_WAIT_W $clog2(`SDRAM_INIT_SUM + 1)

// Refresh timer saturates at the interval
`define SDRAM_REF_W $clog2(`SDRAM_REFRESH_INTERVAL + 1)

`endif

// File: rtl/sdram_pkg.sv
/* SDRAM controller types
   Vector widths, command and sequencer encodings, request and control bundles */
`include "sdram_macros.svh"

package sdram_pkg;

  // Host side address and data
  typedef logic [`SDRAM_HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [`SDRAM_DATA_W-1:0]      sdram_word_t;

  // Device address parts, row width also sizes the address pins
  typedef logic [`SDRAM_COL_W-1:0]  sdram_col_t;
  typedef logic [`SDRAM_ROW_W-1:0]  sdram_row_t;
  typedef logic [`SDRAM_BANK_W-1:0] sdram_bank_t;

  // Sequencer wait counter
  typedef logic [`SDRAM_WAIT_W-1:0] wait_cnt_t;

  // Pin encoding {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_DESELECT  = 4'b1111,
    CMD_NOP       = 4'b0111,
    CMD_READ      = 4'b0101,
    CMD_WRITE     = 4'b0100,
    CMD_ACTIVE    = 4'b0011,
    CMD_PRECHARGE = 4'b0010,
    CMD_REFRESH   = 4'b0001,
    CMD_LOAD_MODE = 4'b0000
  } sdram_cmd_e;

  // Sequencer states
  typedef enum logic [2:0] {
    INIT,
    MODE,
    IDLE,
    REFRESH,
    ACTIVATE,
    READ_A,
    WRITE_A
  } seq_state_e;

  // Registered host request
  typedef struct packed {
    sdram_bank_t bank;
    sdram_row_t  row;
    sdram_col_t  col;
    logic        we;
    logic        rd;
    sdram_word_t wr_data;
  } host_req_t;

  // Control pins as seen by the device
  typedef struct packed {
    sdram_cmd_e  cmd;
    sdram_bank_t bank;
    sdram_row_t  addr;
    logic        cke;
  } sdram_ctrl_t;

endpackage

// File: rtl/sdram_host_port.sv
/* SDRAM host port
   Splits the host address and holds the request taken on accept */
`timescale 1ns/100ps

module sdram_host_port
  import sdram_pkg::*;
(
  input  logic        fpga_clk,
  input  logic        fpga_reset,
  input  logic        accept,
  input  host_addr_t  fpga_addr,
  input  logic        fpga_wr_en,
  input  logic        fpga_rd_en,
  input  sdram_word_t fpga_wr_data,
  output host_req_t   req_q
);

  host_req_t req_d;

  // Host address layout is {bank, row, column}
  always_comb begin
    {req_d.bank, req_d.row, req_d.col} = fpga_addr;
    req_d.we      = fpga_wr_en;
    req_d.rd      = fpga_rd_en;
    req_d.wr_data = fpga_wr_data;
  end

  // Request held here so the host may move on after ack
  // Reloads every accept cycle, so the copy taken with the ACTIVE decision stays
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      req_q <= '0;
    end else if (accept) begin
      req_q <= req_d;
    end
  end

  // Sequencer picks write first, so a host asking for both is a host error
  assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    accept |-> !(fpga_wr_en && fpga_rd_en))
    else $error("host requested write and read together");

endmodule

// File: rtl/sdram_cmd_fsm.sv
/* SDRAM command sequencer
   Power-up, access and refresh sequencing with wait counter and refresh timer */
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_cmd_fsm
  import sdram_pkg::*;
(
  input  logic        fpga_clk,
  input  logic        fpga_reset,
  input  logic        fpga_req,
  input  host_req_t   req_q,
  output logic        accept,
  output logic        fpga_ack,
  output seq_state_e  state,
  output sdram_ctrl_t ctrl
);

  // Decision points one cycle before the command shows on the pins
  localparam wait_cnt_t PRE_AT  = wait_cnt_t'(`SDRAM_INIT_WAIT - 1);
  localparam wait_cnt_t REF1_AT = wait_cnt_t'(`SDRAM_INIT_WAIT + `SDRAM_T_RP - 1);
  localparam wait_cnt_t REF2_AT = wait_cnt_t'(`SDRAM_INIT_WAIT + `SDRAM_T_RP + `SDRAM_T_RC - 1);
  localparam wait_cnt_t MODE_AT = wait_cnt_t'(`SDRAM_INIT_SUM - 1);

  // Last cycle of each timed state
  localparam wait_cnt_t MRD_END   = wait_cnt_t'(`SDRAM_T_MRD - 1);
  localparam wait_cnt_t RCD_END   = wait_cnt_t'(`SDRAM_T_RCD - 1);
  localparam wait_cnt_t READ_END  = wait_cnt_t'(`SDRAM_CAS_LATENCY);
  localparam wait_cnt_t WRITE_END = wait_cnt_t'(`SDRAM_T_WR + `SDRAM_T_RP);
  localparam wait_cnt_t RC_END    = wait_cnt_t'(`SDRAM_T_RC - 1);

  typedef logic [`SDRAM_REF_W-1:0] ref_cnt_t;
  localparam ref_cnt_t REF_LIMIT = ref_cnt_t'(`SDRAM_REFRESH_INTERVAL);

  // A10 selects all banks on precharge and auto-precharge on read/write
  localparam sdram_row_t A10 = sdram_row_t'(1 << 10);

  seq_state_e state_d;
  sdram_cmd_e cmd_d;
  sdram_cmd_e cmd_q;
  logic       cke_q;
  wait_cnt_t  wait_cnt;
  ref_cnt_t   ref_timer;
  logic       refresh_due;
  logic       read_done;
  logic       write_done;
  logic       ref_done;

  assign read_done   = (state == READ_A) && (wait_cnt == READ_END);
  assign write_done  = (state == WRITE_A) && (wait_cnt == WRITE_END);
  assign ref_done    = (state == REFRESH) && (wait_cnt == RC_END);
  assign refresh_due = (ref_timer == REF_LIMIT);

  // New work taken in idle or in the last cycle of an access or refresh
  assign accept = (state == IDLE) || read_done || write_done || ref_done;

  // Next state and command
  always_comb begin
    state_d = state;
    cmd_d   = CMD_NOP;
    case (state)
      // Power-up runs on one count
      INIT: begin
        if (wait_cnt == PRE_AT) begin
          cmd_d = CMD_PRECHARGE;
        end else if ((wait_cnt == REF1_AT) || (wait_cnt == REF2_AT)) begin
          cmd_d = CMD_REFRESH;
        end else if (wait_cnt == MODE_AT) begin
          state_d = MODE;
          cmd_d   = CMD_LOAD_MODE;
        end
      end
      MODE: begin
        if (wait_cnt == MRD_END) state_d = IDLE;
      end
      // Row is open so the column access goes out
      // No direction set means back to idle
      ACTIVATE: begin
        if (wait_cnt == RCD_END) begin
          if (req_q.we) begin
            state_d = WRITE_A;
            cmd_d   = CMD_WRITE;
          end else if (req_q.rd) begin
            state_d = READ_A;
            cmd_d   = CMD_READ;
          end else begin
            state_d = IDLE;
          end
        end
      end
      // IDLE, REFRESH, READ_A and WRITE_A share the accept decision
      default: begin
        if (accept) begin
          if (refresh_due) begin
            state_d = REFRESH;
            cmd_d   = CMD_REFRESH;
          end else if (fpga_req) begin
            state_d = ACTIVATE;
            cmd_d   = CMD_ACTIVE;
          end else begin
            state_d = IDLE;
          end
        end
      end
    endcase
  end

  // State, command and ack move together
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      state    <= INIT;
      cmd_q    <= CMD_NOP;
      cke_q    <= 1'b0;
      fpga_ack <= 1'b0;
      wait_cnt <= '0;
    end else begin
      state    <= state_d;
      cmd_q    <= cmd_d;
      cke_q    <= 1'b1;
      fpga_ack <= (cmd_d == CMD_READ) || (cmd_d == CMD_WRITE);
      // Restart on every state change
      wait_cnt <= (state_d != state) ? '0 : wait_cnt + 1'b1;
    end
  end

  // Refresh timer clears as REFRESH starts and holds at the limit
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      ref_timer <= '0;
    end else if ((state_d == REFRESH) && (state != REFRESH)) begin
      ref_timer <= '0;
    end else if (!refresh_due) begin
      ref_timer <= ref_timer + 1'b1;
    end
  end

  // Address and bank follow the current state
  always_comb begin
    ctrl.cmd  = cmd_q;
    ctrl.cke  = cke_q;
    ctrl.bank = '0;
    ctrl.addr = '0;
    case (state)
      INIT:     ctrl.addr = A10;
      MODE:     ctrl.addr = `SDRAM_MODE_REG;
      ACTIVATE: begin
        ctrl.bank = req_q.bank;
        ctrl.addr = req_q.row;
      end
      READ_A, WRITE_A: begin
        ctrl.bank = req_q.bank;
        ctrl.addr = A10 | sdram_row_t'(req_q.col);
      end
      default: ;
    endcase
  end

  // Ack lasts one cycle
  assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    fpga_ack |=> !fpga_ack)
    else $error("fpga_ack is not a single pulse");

  // Refresh only reached from normal operation, never from power-up
  assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    (state != REFRESH) ##1 (state == REFRESH) |-> $past(state) inside {IDLE, READ_A, WRITE_A})
    else $error("REFRESH entered before init completed");

endmodule

// File: rtl/sdram_pin_driver.sv
/* SDRAM pin driver
   Puts control on the pins, drives write data and captures read data */
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_pin_driver
  import sdram_pkg::*;
(
  input  logic             fpga_clk,
  input  logic             fpga_reset,
  input  sdram_ctrl_t      ctrl,
  input  seq_state_e       state,
  input  host_req_t        req_q,
  output sdram_row_t       ram_addr,
  output sdram_bank_t      ram_bank_addr,
  output logic             ram_cs_n,
  output logic             ram_ras_n,
  output logic             ram_cas_n,
  output logic             ram_we_n,
  output logic             ram_clk_en,
  output logic             ram_clk,
  output sdram_word_t      fpga_rd_data,
  inout  wire sdram_word_t ram_data
);

  localparam int CAS_W = $clog2(`SDRAM_CAS_LATENCY + 1);
  typedef logic [CAS_W-1:0] cas_cnt_t;
  localparam cas_cnt_t CAS_AT = cas_cnt_t'(`SDRAM_CAS_LATENCY);

  cas_cnt_t   cas_cnt;
  seq_state_e state_q;
  logic       bus_oe;
  logic       rd_capture;

  // Control pins straight from the sequencer
  assign {ram_cs_n, ram_ras_n, ram_cas_n, ram_we_n} = ctrl.cmd;
  assign ram_addr      = ctrl.addr;
  assign ram_bank_addr = ctrl.bank;
  assign ram_clk_en    = ctrl.cke;
  assign ram_clk       = fpga_clk;

  // Previous sequencer state marks the first cycle of WRITE_A
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      state_q <= INIT;
    end else begin
      state_q <= state;
    end
  end

  // Write word only in the first WRITE_A cycle
  assign bus_oe   = (state == WRITE_A) && (state_q != WRITE_A);
  assign ram_data = bus_oe ? req_q.wr_data : 'z;

  // Counts cycles since the READ command and stays zero outside READ_A
  always_ff @(posedge fpga_clk or posedge fpga_reset) begin
    if (fpga_reset) begin
      cas_cnt <= '0;
    end else if (state != READ_A) begin
      cas_cnt <= '0;
    end else begin
      cas_cnt <= cas_cnt + 1'b1;
    end
  end

  // Data valid CAS latency after READ in the last READ_A cycle
  assign rd_capture = (state == READ_A) && (cas_cnt == CAS_AT);

  // Holds until the next read
  always_ff @(posedge fpga_clk) begin
    if (rd_capture) begin
      fpga_rd_data <= ram_data;
    end
  end

  // Bus driven only while the WRITE command is on the pins
  assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    bus_oe |-> (ctrl.cmd == CMD_WRITE))
    else $error("data bus driven outside a WRITE command");

  // Capture lines up with the READ issued CAS latency earlier
  assert property (@(posedge fpga_clk) disable iff (fpga_reset)
    rd_capture |-> $past(ctrl.cmd, `SDRAM_CAS_LATENCY) == CMD_READ)
    else $error("read capture not aligned to CAS latency");

endmodule

// File: rtl/sdram_controller.sv
/* SDRAM controller top
   Host request port, command sequencer and pin driver */
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_controller
  import sdram_pkg::*;
(
  input  logic                    fpga_clk,
  input  logic                    fpga_reset,
  // Host side
  input  logic                    fpga_req,
  input  host_addr_t              fpga_addr,
  input  logic                    fpga_wr_en,
  input  logic                    fpga_rd_en,
  input  sdram_word_t             fpga_wr_data,
  output logic                    fpga_ack,
  output sdram_word_t             fpga_rd_data,
  // Device side
  output sdram_row_t              ram_addr,
  output sdram_bank_t             ram_bank_addr,
  output logic [`SDRAM_DQM_W-1:0] ram_dqm,
  inout  wire sdram_word_t        ram_data,
  output logic                    ram_cs_n,
  output logic                    ram_ras_n,
  output logic                    ram_cas_n,
  output logic                    ram_we_n,
  output logic                    ram_clk_en,
  output logic                    ram_clk
);

  logic        accept;
  host_req_t   req_q;
  seq_state_e  state;
  sdram_ctrl_t ctrl;

  // No byte masking
  assign ram_dqm = '0;

  sdram_host_port sdram_host_port_inst (
    .fpga_clk     (fpga_clk),
    .fpga_reset   (fpga_reset),
    .accept       (accept),
    .fpga_addr    (fpga_addr),
    .fpga_wr_en   (fpga_wr_en),
    .fpga_rd_en   (fpga_rd_en),
    .fpga_wr_data (fpga_wr_data),
    .req_q        (req_q)
  );

  sdram_cmd_fsm sdram_cmd_fsm_inst (
    .fpga_clk   (fpga_clk),
    .fpga_reset (fpga_reset),
    .fpga_req   (fpga_req),
    .req_q      (req_q),
    .accept     (accept),
    .fpga_ack   (fpga_ack),
    .state      (state),
    .ctrl       (ctrl)
  );

  sdram_pin_driver sdram_pin_driver_inst (
    .fpga_clk      (fpga_clk),
    .fpga_reset    (fpga_reset),
    .ctrl          (ctrl),
    .state         (state),
    .req_q         (req_q),
    .ram_addr      (ram_addr),
    .ram_bank_addr (ram_bank_addr),
    .ram_cs_n      (ram_cs_n),
    .ram_ras_n     (ram_ras_n),
    .ram_cas_n     (ram_cas_n),
    .ram_we_n      (ram_we_n),
    .ram_clk_en    (ram_clk_en),
    .ram_clk       (ram_clk),
    .fpga_rd_data  (fpga_rd_data),
    .ram_data      (ram_data)
  );

endmodule

// File: test/sdram_controller_tb.sv
/* SDRAM controller testbench
   Plays host vectors against a small device model and checks command timing */
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_controller_tb
  import sdram_pkg::*;
();

  // Cycles a WRITE_A and a READ_A state occupy, and one full access
  localparam int WRITE_SPAN  = 1 + `SDRAM_T_WR + `SDRAM_T_RP;
  localparam int READ_SPAN   = `SDRAM_CAS_LATENCY + 1;
  localparam int ACCESS_SPAN = `SDRAM_T_RCD + WRITE_SPAN;
  localparam int MAX_VEC     = 32;
  localparam int MAX_PASS    = 6;
  localparam sdram_row_t A10 = 12'h400;
  // M9 single-location write, CAS latency in M6:M4, sequential burst of one
  localparam sdram_row_t MODE_WORD = sdram_row_t'((1 << 9) | (`SDRAM_CAS_LATENCY << 4));

  logic fpga_clk;
  logic fpga_reset;
  logic fpga_req;
  host_addr_t fpga_addr;
  logic fpga_wr_en;
  logic fpga_rd_en;
  sdram_word_t fpga_wr_data;
  logic fpga_ack;
  sdram_word_t fpga_rd_data;
  sdram_row_t ram_addr;
  sdram_bank_t ram_bank_addr;
  logic [`SDRAM_DQM_W-1:0] ram_dqm;
  wire sdram_word_t ram_data;
  logic ram_cs_n;
  logic ram_ras_n;
  logic ram_cas_n;
  logic ram_we_n;
  logic ram_clk_en;
  logic ram_clk;
  sdram_cmd_e pin_cmd;

  // Vector table
  byte         vec_op [MAX_VEC];
  host_addr_t  vec_addr [MAX_VEC];
  sdram_word_t vec_wdata [MAX_VEC];
  sdram_word_t vec_rdata [MAX_VEC];
  int          n_vec;

  // Device model state
  sdram_row_t  open_row [4];
  host_addr_t  stored_key [MAX_VEC];
  sdram_word_t stored_word [MAX_VEC];
  int          n_stored;
  int          rd_count;
  host_addr_t  rd_key;
  host_addr_t  model_key;
  logic        model_oe;
  sdram_word_t model_data;

  // Checker bookkeeping where cycle numbers count rising edges
  int          cyc = 0;
  int          rel_cyc;
  int          prev_ref_cyc;
  int          ref_seen;
  logic        rd_pending;
  int          rd_due;
  sdram_word_t rd_expect;

  sdram_controller sdram_controller_inst (
    .fpga_clk      (fpga_clk),
    .fpga_reset    (fpga_reset),
    .fpga_req      (fpga_req),
    .fpga_addr     (fpga_addr),
    .fpga_wr_en    (fpga_wr_en),
    .fpga_rd_en    (fpga_rd_en),
    .fpga_wr_data  (fpga_wr_data),
    .fpga_ack      (fpga_ack),
    .fpga_rd_data  (fpga_rd_data),
    .ram_addr      (ram_addr),
    .ram_bank_addr (ram_bank_addr),
    .ram_dqm       (ram_dqm),
    .ram_data      (ram_data),
    .ram_cs_n      (ram_cs_n),
    .ram_ras_n     (ram_ras_n),
    .ram_cas_n     (ram_cas_n),
    .ram_we_n      (ram_we_n),
    .ram_clk_en    (ram_clk_en),
    .ram_clk       (ram_clk)
  );

  assign pin_cmd  = sdram_cmd_e'({ram_cs_n, ram_ras_n, ram_cas_n, ram_we_n});
  assign ram_data = model_oe ? model_data : 'z;

  initial begin
    fpga_clk = 1'b0;
    forever #5 fpga_clk = ~fpga_clk;
  end

  always @(posedge fpga_clk) cyc <= cyc + 1;

  // Command log sampled mid-cycle
  always @(negedge fpga_clk) begin
    if (!fpga_reset && (pin_cmd != CMD_NOP)) begin
      $display("cycle %0d %s bank %h addr %h", cyc, pin_cmd.name(), ram_bank_addr, ram_addr);
    end
  end

  function automatic int find_word(input host_addr_t key);
    int hit;
    hit = -1;
    for (int k = 0; k < n_stored; k++) begin
      if (stored_key[k] == key) hit = k;
    end
    return hit;
  endfunction

  // Device model reacting just after the edge that put a command on the pins
  always @(posedge fpga_clk) begin
    #1;
    if (rd_count != 0) begin
      rd_count = rd_count - 1;
      model_oe = (rd_count == 0);
      if (model_oe) begin
        model_data = (find_word(rd_key) < 0) ? 'x : stored_word[find_word(rd_key)];
      end
    end else begin
      model_oe = 1'b0;
    end
    model_key = host_addr_t'({ram_bank_addr, open_row[ram_bank_addr], sdram_col_t'(ram_addr)});
    case (pin_cmd)
      CMD_ACTIVE: open_row[ram_bank_addr] = ram_addr;
      CMD_WRITE: begin
        if (find_word(model_key) < 0) begin
          stored_key[n_stored] = model_key;
          stored_word[n_stored] = ram_data;
          n_stored = n_stored + 1;
        end else begin
          stored_word[find_word(model_key)] = ram_data;
        end
      end
      // Data goes out CAS latency cycles after the READ
      CMD_READ: begin
        rd_key   = model_key;
        rd_count = `SDRAM_CAS_LATENCY;
      end
      default: ;
    endcase
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "testbench stopped at cycle %0d", cyc);
  endtask

  task automatic check_cmd(input string name, input sdram_cmd_e got, input sdram_cmd_e exp);
    if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input sdram_row_t got, input sdram_row_t exp);
    if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bank(input string name, input sdram_bank_t got, input sdram_bank_t exp);
    if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_word(input string name, input sdram_word_t got, input sdram_word_t exp);
    if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  // Cycle distance between lo and hi with equal bounds for exact spacing
  task automatic check_gap(input string name, input int got, input int lo, input int hi);
    if ((got < lo) || (got > hi)) begin
      stop_run($sformatf("[FAIL] %s got %h expected %h to %h", name, got, lo, hi));
    end
  endtask

  // Device clock follows the controller clock in both phases
  always @(fpga_clk) begin
    #1;
    check_bit("ram_clk", ram_clk, fpga_clk);
  end

  // Checks that hold in every cycle
  task automatic cycle_checks();
    check_bit("ram_clk_en", ram_clk_en, cyc != rel_cyc);
    check_bit("fpga_ack", fpga_ack, pin_cmd inside {CMD_READ, CMD_WRITE});
    check_bit("ram_dqm", |ram_dqm, 1'b0);
    if (!model_oe && (pin_cmd != CMD_WRITE)) check_word("ram_data", ram_data, 'z);
    if (rd_pending && (cyc == rd_due)) begin
      check_word("fpga_rd_data", fpga_rd_data, rd_expect);
      rd_pending = 1'b0;
    end
  endtask

  // Steps cycles until a command other than NOP shows up
  task automatic next_command(input int limit, output sdram_cmd_e cmd, output int at);
    int waited;
    waited = 0;
    cmd = CMD_NOP;
    while (cmd == CMD_NOP) begin
      if (waited == limit) begin
        stop_run($sformatf("no command on the pins within %0d cycles", limit));
      end
      @(negedge fpga_clk);
      waited++;
      cycle_checks();
      cmd = pin_cmd;
    end
    at = cyc;
  endtask

  task automatic load_vectors();
    int fd;
    int rc;
    string line;
    byte op;
    host_addr_t ad;
    sdram_word_t wd;
    sdram_word_t rd;
    n_vec = 0;
    fd = $fopen("test/sdram_vectors.txt", "r");
    if (fd == 0) stop_run("cannot open test/sdram_vectors.txt");
    while (!$feof(fd) && (n_vec < MAX_VEC)) begin
      line = "";
      rc = $fgets(line, fd);
      if ((line.len() > 1) && (line.getc(0) != "#")) begin
        rc = $sscanf(line, "%c %h %h %h", op, ad, wd, rd);
        if (rc == 4) begin
          vec_op[n_vec]    = op;
          vec_addr[n_vec]  = ad;
          vec_wdata[n_vec] = wd;
          vec_rdata[n_vec] = rd;
          n_vec++;
        end
      end
    end
    $fclose(fd);
    if (n_vec == 0) stop_run("vector file holds no operations");
  endtask

  task automatic drive_vector(input int idx);
    fpga_req     = 1'b1;
    fpga_addr    = vec_addr[idx];
    fpga_wr_en   = (vec_op[idx] == "W");
    fpga_rd_en   = (vec_op[idx] == "R");
    fpga_wr_data = vec_wdata[idx];
  endtask

  // Power-up order and spacing with the expected slot of the first ACTIVE as result
  task automatic run_init(output int slot);
    sdram_cmd_e cmd;
    int at;
    int last;
    next_command(`SDRAM_INIT_WAIT + 5, cmd, at);
    check_cmd("init command 1", cmd, CMD_PRECHARGE);
    check_addr("precharge ram_addr", ram_addr, A10);
    check_gap("power-up wait", at - rel_cyc, `SDRAM_INIT_WAIT, `SDRAM_INIT_WAIT);
    last = at;
    next_command(`SDRAM_T_RP + 5, cmd, at);
    check_cmd("init command 2", cmd, CMD_REFRESH);
    check_gap("precharge to refresh", at - last, `SDRAM_T_RP, `SDRAM_T_RP);
    last = at;
    next_command(`SDRAM_T_RC + 5, cmd, at);
    check_cmd("init command 3", cmd, CMD_REFRESH);
    check_gap("refresh to refresh", at - last, `SDRAM_T_RC, `SDRAM_T_RC);
    last = at;
    next_command(`SDRAM_T_RC + 5, cmd, at);
    check_cmd("init command 4", cmd, CMD_LOAD_MODE);
    check_gap("refresh to load mode", at - last, `SDRAM_T_RC, `SDRAM_T_RC);
    check_addr("mode ram_addr", ram_addr, MODE_WORD);
    slot = at + `SDRAM_T_MRD + 1;
  endtask

  // One access where a refresh may take the ACTIVE slot first
  task automatic play_access(input int idx, input int slot, output int next_slot);
    sdram_cmd_e cmd;
    sdram_cmd_e col_cmd;
    int at;
    sdram_bank_t bk;
    sdram_row_t rw;
    sdram_col_t cl;
    {bk, rw, cl} = vec_addr[idx];
    next_command(WRITE_SPAN + 5, cmd, at);
    if (cmd == CMD_REFRESH) begin
      check_gap("refresh slot", at, slot, slot);
      check_gap("refresh spacing", at - prev_ref_cyc, `SDRAM_REFRESH_INTERVAL + 1,
                `SDRAM_REFRESH_INTERVAL + ACCESS_SPAN);
      prev_ref_cyc = at;
      ref_seen++;
      slot = at + `SDRAM_T_RC;
      next_command(`SDRAM_T_RC + 5, cmd, at);
    end
    check_cmd("access command", cmd, CMD_ACTIVE);
    check_gap("ACTIVE slot", at, slot, slot);
    check_bank("ACTIVE ram_bank_addr", ram_bank_addr, bk);
    check_addr("ACTIVE ram_addr", ram_addr, rw);
    col_cmd = (vec_op[idx] == "W") ? CMD_WRITE : CMD_READ;
    slot = at + `SDRAM_T_RCD;
    next_command(`SDRAM_T_RCD + 5, cmd, at);
    check_cmd("column command", cmd, col_cmd);
    check_gap("column slot", at, slot, slot);
    check_bank("column ram_bank_addr", ram_bank_addr, bk);
    check_addr("column ram_addr", ram_addr, A10 | sdram_row_t'(cl));
    if (col_cmd == CMD_WRITE) begin
      check_word("ram_data", ram_data, vec_wdata[idx]);
      next_slot = at + WRITE_SPAN;
    end else begin
      rd_pending = 1'b1;
      rd_due     = at + `SDRAM_CAS_LATENCY + 1;
      rd_expect  = vec_rdata[idx];
      next_slot  = at + READ_SPAN;
    end
  endtask

  initial begin
    int slot;
    int refs_before;
    logic done;
    sdram_cmd_e cmd;
    int at;
    fpga_reset   = 1'b1;
    fpga_req     = 1'b0;
    fpga_addr    = '0;
    fpga_wr_en   = 1'b0;
    fpga_rd_en   = 1'b0;
    fpga_wr_data = '0;
    model_oe     = 1'b0;
    model_data   = '0;
    rd_count     = 0;
    n_stored     = 0;
    ref_seen     = 0;
    rd_pending   = 1'b0;
    rel_cyc      = 0;
    done         = 1'b0;
    load_vectors();
    repeat (4) @(posedge fpga_clk);
    #1;
    fpga_reset   = 1'b0;
    rel_cyc      = cyc;
    prev_ref_cyc = cyc;
    // First request already waiting while power-up runs
    drive_vector(0);
    run_init(slot);
    // Back-to-back passes until a refresh has cut into the stream
    for (int pass = 0; (pass < MAX_PASS) && !done; pass++) begin
      refs_before = ref_seen;
      for (int i = 0; i < n_vec; i++) begin
        if ((pass != 0) || (i != 0)) begin
          @(posedge fpga_clk);
          #1;
          drive_vector(i);
        end
        play_access(i, slot, slot);
      end
      done = (ref_seen > refs_before);
    end
    if (ref_seen == 0) stop_run("no refresh appeared during back-to-back requests");
    @(posedge fpga_clk);
    #1;
    fpga_req   = 1'b0;
    fpga_wr_en = 1'b0;
    fpga_rd_en = 1'b0;
    // Idle refreshes
    next_command(`SDRAM_REFRESH_INTERVAL + ACCESS_SPAN + 5, cmd, at);
    check_cmd("idle command 1", cmd, CMD_REFRESH);
    check_gap("refresh spacing", at - prev_ref_cyc, `SDRAM_REFRESH_INTERVAL + 1,
              `SDRAM_REFRESH_INTERVAL + ACCESS_SPAN);
    prev_ref_cyc = at;
    next_command(`SDRAM_REFRESH_INTERVAL + 5, cmd, at);
    check_cmd("idle command 2", cmd, CMD_REFRESH);
    check_gap("idle refresh spacing", at - prev_ref_cyc, `SDRAM_REFRESH_INTERVAL + 1,
              `SDRAM_REFRESH_INTERVAL + 1);
    if (rd_pending) begin
      stop_run("read data was never checked after the last read");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: test/sdram_vectors.txt
# op (W write, R read), host address {bank, row, col} hex, write data hex, expected read data hex
# Reads refer to addresses written earlier in this file
W 000000 a5a50001 00000000
W 0001ff 5a5a0002 00000000
W 200a05 12345678 00000000
W 400c03 deadbeef 00000000
W 7fffff cafef00d 00000000
W 123456 0badc0de 00000000
W 5abcde 13572468 00000000
W 654321 fedcba98 00000000
R 000000 00000000 a5a50001
R 0001ff 00000000 5a5a0002
R 200a05 00000000 12345678
R 400c03 00000000 deadbeef
R 7fffff 00000000 cafef00d
R 123456 00000000 0badc0de
R 5abcde 00000000 13572468
R 654321 00000000 fedcba98
R 7fffff 00000000 cafef00d
R 000000 00000000 a5a50001

// File: tb.f
+incdir+rtl
rtl/sdram_pkg.sv
rtl/sdram_host_port.sv
rtl/sdram_cmd_fsm.sv
rtl/sdram_pin_driver.sv
rtl/sdram_controller.sv
test/sdram_controller_tb.sv
